// ==== source/arcade_pkg.sv ====
`default_nettype none

package arcade_pkg;

	// ==================================================
	// Sound port and sound state
	// ==================================================
	localparam int PORT_W  = 6;
	localparam int SOUND_W = 2 * PORT_W;

	// Port 0 in bits 5..0, port 1 in bits 11..6
	typedef logic [SOUND_W-1:0] sound_state_t;

	// ==================================================
	// Audio
	// ==================================================
	localparam int SAMPLE_W = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Level added by one voice while its square wave is high
	localparam int unsigned VOICE_AMP = 40;

	localparam int HALF_W = 16;

	// Half period in clk_sys cycles, one entry per voice index
	localparam logic [HALF_W-1:0] HALF_PERIOD [SOUND_W] = '{
		16'd37,  16'd53,  16'd71,  16'd89,
		16'd113, 16'd131, 16'd157, 16'd181,
		16'd211, 16'd241, 16'd263, 16'd293
	};

	// ==================================================
	// Video
	// ==================================================
	localparam int LINE_W = 9;

endpackage

`default_nettype wire

// ==== source/control_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_merge #(
	parameter int unsigned COIN_PULSE = 16
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [7:0] kbjoy,
	input  logic [7:0] joy0,
	input  logic [7:0] joy1,
	input  logic       upright,
	output logic       move_left,
	output logic       move_right,
	output logic       fire,
	output logic       start1,
	output logic       start2,
	output logic       coin
);

	localparam int CNT_W = $clog2(COIN_PULSE + 1);

	logic             left_c;
	logic             right_c;
	logic             coin_key_d;
	logic             coin_edge;
	logic [CNT_W-1:0] coin_cnt;

	// Stick directions swap with cabinet orientation
	assign left_c = upright ? (kbjoy[5] | joy0[2] | joy1[2])
	                        : (kbjoy[6] | joy0[1] | joy1[1]);
	assign right_c = upright ? (kbjoy[4] | joy0[3] | joy1[3])
	                         : (kbjoy[7] | joy0[0] | joy1[0]);

	assign coin_edge = kbjoy[3] && !coin_key_d;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			move_left  <= 1'b0;
			move_right <= 1'b0;
			fire       <= 1'b0;
			start1     <= 1'b0;
			start2     <= 1'b0;
			coin_key_d <= 1'b0;
			coin       <= 1'b0;
			coin_cnt   <= '0;
		end else begin
			move_left  <= left_c;
			move_right <= right_c;
			fire       <= kbjoy[0] | joy0[4] | joy1[4];
			start1     <= kbjoy[1];
			start2     <= kbjoy[2];
			coin_key_d <= kbjoy[3];

			// One-shot, retrigger blocked until the pulse ends
			if (coin) begin
				if (coin_cnt == '0)
					coin <= 1'b0;
				else
					coin_cnt <= coin_cnt - 1'b1;
			end else if (coin_edge) begin
				coin     <= 1'b1;
				coin_cnt <= CNT_W'(COIN_PULSE - 1);
			end
		end
	end

	a_coin_len: assert property (@(posedge clk_sys) disable iff (!rst_n)
		coin [*COIN_PULSE] |=> !coin);

endmodule

`default_nettype wire

// ==== source/sound_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module sound_latch (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          snd_req,
	input  logic                          snd_port,
	input  logic [arcade_pkg::PORT_W-1:0] snd_data,
	output logic                          snd_ack,
	output arcade_pkg::sound_state_t      sound_state
);

	import arcade_pkg::*;

	logic take;
	logic release_ack;

	// New request seen while idle
	assign take = snd_req && !snd_ack;

	// Requester has dropped req so the handshake closes
	assign release_ack = !snd_req && snd_ack;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			snd_ack     <= 1'b0;
			sound_state <= '0;
		end else begin
			if (take) begin
				snd_ack <= 1'b1;
				if (snd_port)
					sound_state[SOUND_W-1:PORT_W] <= snd_data;
				else
					sound_state[PORT_W-1:0] <= snd_data;
			end else if (release_ack) begin
				snd_ack <= 1'b0;
			end
		end
	end

	// ==================================================
	// Handshake checks
	// ==================================================

	// ack only rises in answer to req
	a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!snd_req && !snd_ack |=> !snd_ack);

endmodule

`default_nettype wire

// ==== source/tone_voice.sv ====
`timescale 1ns/1ns
`default_nettype none

module tone_voice #(
	parameter logic [arcade_pkg::HALF_W-1:0] HALF_PERIOD_CYCLES = 16'd37
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic enable,
	output logic tone
);

	import arcade_pkg::*;

	logic [HALF_W-1:0] phase_cnt;
	logic              wrap;

	assign wrap = (phase_cnt == HALF_PERIOD_CYCLES - 1'b1);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase_cnt <= '0;
			tone      <= 1'b0;
		end else if (!enable) begin
			// Voice off restarts from phase zero
			phase_cnt <= '0;
			tone      <= 1'b0;
		end else if (wrap) begin
			phase_cnt <= '0;
			tone      <= ~tone;
		end else begin
			phase_cnt <= phase_cnt + 1'b1;
		end
	end

	a_cnt_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		phase_cnt < HALF_PERIOD_CYCLES);

endmodule

`default_nettype wire

// ==== source/voice_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module voice_mixer #(
	parameter int NUM_VOICES = 8
) (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic [NUM_VOICES-1:0] tones,
	output arcade_pkg::sample_t   audio_sample
);

	import arcade_pkg::*;

	localparam int MAX_SUM = NUM_VOICES * VOICE_AMP;
	localparam int SUM_W   = ($clog2(MAX_SUM + 1) > SAMPLE_W) ? $clog2(MAX_SUM + 1)
	                                                          : SAMPLE_W + 1;

	logic [SUM_W-1:0] sum;
	logic             over;

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_VOICES; i++) begin
			if (tones[i])
				sum = sum + SUM_W'(VOICE_AMP);
		end
	end

	// Clip anything past full scale
	assign over = (sum > SUM_W'({SAMPLE_W{1'b1}}));

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			audio_sample <= '0;
		else if (over)
			audio_sample <= '1;
		else
			audio_sample <= sum[SAMPLE_W-1:0];
	end

endmodule

`default_nettype wire

// ==== source/sigma_delta_dac.sv ====
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::sample_t sample,
	output logic                audio_bit
);

	import arcade_pkg::*;

	// Low bits hold the running error, top bit is the carry out
	logic [SAMPLE_W:0] acc;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[SAMPLE_W-1:0]} + {1'b0, sample};
	end

	// Carry of the last add, so L ones per 256 cycles for a steady L
	assign audio_bit = acc[SAMPLE_W];

endmodule

`default_nettype wire

// ==== source/overlay_colorizer.sv ====
`timescale 1ns/1ns
`default_nettype none

module overlay_colorizer #(
	parameter int unsigned RED_END     = 32,
	parameter int unsigned GREEN_START = 184
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic video,
	input  logic hs_in,
	input  logic vs_in,
	output logic r,
	output logic g,
	output logic b,
	output logic hs,
	output logic vs
);

	import arcade_pkg::*;

	logic [LINE_W-1:0] line_cnt;
	logic              hs_rise;
	logic              red_band;
	logic              green_band;

	// hs is hs_in one cycle late, which is all the edge detect needs
	assign hs_rise = hs_in && !hs;

	assign red_band   = (line_cnt < LINE_W'(RED_END));
	assign green_band = (line_cnt >= LINE_W'(GREEN_START));

	// ==================================================
	// Raster line counter
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			line_cnt <= '0;
		else if (vs_in)
			line_cnt <= '0;
		else if (hs_rise)
			line_cnt <= line_cnt + 1'b1;
	end

	// ==================================================
	// Overlay colour and sync delay
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			r  <= 1'b0;
			g  <= 1'b0;
			b  <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
		end else begin
			// Red strip on top, green strip at the bottom, white in between
			r  <= video && !green_band;
			g  <= video && !red_band;
			b  <= video && !red_band && !green_band;
			hs <= hs_in;
			vs <= vs_in;
		end
	end

endmodule

`default_nettype wire

// ==== source/arcade_board.sv ====
`timescale 1ns/1ns
`default_nettype none

module arcade_board #(
	parameter int          NUM_VOICES  = 8,
	parameter int unsigned COIN_PULSE  = 16,
	parameter int unsigned RED_END     = 32,
	parameter int unsigned GREEN_START = 184
) (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [7:0]                    kbjoy,
	input  logic [7:0]                    joy0,
	input  logic [7:0]                    joy1,
	input  logic                          upright,
	input  logic                          snd_req,
	input  logic                          snd_port,
	input  logic [arcade_pkg::PORT_W-1:0] snd_data,
	output logic                          snd_ack,
	input  logic                          video,
	input  logic                          hs_in,
	input  logic                          vs_in,
	output logic                          move_left,
	output logic                          move_right,
	output logic                          fire,
	output logic                          start1,
	output logic                          start2,
	output logic                          coin,
	output arcade_pkg::sample_t           audio_sample,
	output logic                          audio_bit,
	output logic                          r,
	output logic                          g,
	output logic                          b,
	output logic                          hs,
	output logic                          vs
);

	import arcade_pkg::*;

	sound_state_t          sound_state;
	logic [NUM_VOICES-1:0] tones;

	if (NUM_VOICES < 1 || NUM_VOICES > SOUND_W) begin : g_bad_voices
		$error("NUM_VOICES out of range");
	end

	// ==================================================
	// Controls
	// ==================================================
	control_merge #(.COIN_PULSE(COIN_PULSE)) control_merge (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.kbjoy(kbjoy), .joy0(joy0), .joy1(joy1), .upright(upright),
		.move_left(move_left), .move_right(move_right), .fire(fire),
		.start1(start1), .start2(start2), .coin(coin)
	);

	// ==================================================
	// Sound
	// ==================================================
	sound_latch sound_latch (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.snd_req(snd_req), .snd_port(snd_port), .snd_data(snd_data),
		.snd_ack(snd_ack), .sound_state(sound_state)
	);

	// One voice per sound state bit, pitch from its index
	for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
		tone_voice #(.HALF_PERIOD_CYCLES(HALF_PERIOD[i])) voice (
			.clk_sys(clk_sys), .rst_n(rst_n),
			.enable(sound_state[i]), .tone(tones[i])
		);
	end

	voice_mixer #(.NUM_VOICES(NUM_VOICES)) voice_mixer (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.tones(tones), .audio_sample(audio_sample)
	);

	sigma_delta_dac dac (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.sample(audio_sample), .audio_bit(audio_bit)
	);

	// ==================================================
	// Video
	// ==================================================
	overlay_colorizer #(.RED_END(RED_END), .GREEN_START(GREEN_START)) overlay_colorizer (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.video(video), .hs_in(hs_in), .vs_in(vs_in),
		.r(r), .g(g), .b(b), .hs(hs), .vs(vs)
	);

endmodule

`default_nettype wire

// ==== bench/tb_models.svh ====
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// ==================================================
// Random source
// ==================================================

// Galois LFSR, one step per bit taken, first bit ends up in the MSB
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};
		lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
	end
	return v;
endfunction

// ==================================================
// Reference models
// ==================================================

// {left, right, fire, start1, start2}
function automatic logic [4:0] ctrl_ref(input logic [7:0] kb, input logic [7:0] j0,
		input logic [7:0] j1, input logic up);
	logic [7:0] sticks;
	logic       left;
	logic       right;
	sticks = j0 | j1;
	if (up) begin
		left  = kb[5] | sticks[2];
		right = kb[4] | sticks[3];
	end else begin
		left  = kb[6] | sticks[1];
		right = kb[7] | sticks[0];
	end
	return {left, right, kb[0] | sticks[4], kb[1], kb[2]};
endfunction

// Voice state is {tone, elapsed cycles in this half period}
function automatic logic [16:0] voice_step(input logic en, input logic [16:0] st, input int hp);
	logic tone;
	int   cnt;
	tone = st[16];
	cnt  = st[15:0];
	if (!en)
		return 17'd0;
	cnt++;
	if (cnt == hp) begin
		tone = !tone;
		cnt  = 0;
	end
	return {tone, 16'(cnt)};
endfunction

function automatic logic [7:0] mix_level(input logic [NUM_VOICES-1:0] tones);
	int lvl;
	lvl = 0;
	for (int i = 0; i < NUM_VOICES; i++) begin
		if (tones[i])
			lvl += VOICE_AMP;
	end
	if (lvl > 255)
		lvl = 255;
	return 8'(lvl);
endfunction

// Bit 8 is the output bit, low byte the new remainder
function automatic logic [8:0] dac_step(input logic [7:0] rem, input logic [7:0] level);
	return {1'b0, rem} + {1'b0, level};
endfunction

// {r, g, b} for one pixel
function automatic logic [2:0] overlay_rgb(input int line, input logic pix);
	if (!pix)
		return 3'b000;
	if (line < RED_END)
		return 3'b100;
	else if (line >= GREEN_START)
		return 3'b010;
	else
		return 3'b111;
endfunction

task automatic check_value(input int grp, input string what, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		err_count[grp]++;
		$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
	end
endtask

`endif

// ==== bench/tb_arcade_board.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_arcade_board;

	localparam int NUM_VOICES  = 8;
	localparam int COIN_PULSE  = 16;
	localparam int RED_END     = 32;
	localparam int GREEN_START = 184;
	localparam int VOICE_AMP   = 40;
	localparam int HP_TABLE [12] = '{37, 53, 71, 89, 113, 131, 157, 181, 211, 241, 263, 293};

	// Phase lengths in clock cycles
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES  = 20;
	localparam int CTRL_STEPS   = 300;
	localparam int NUM_WRITES   = 30;
	localparam int GAP_BASE     = 150;
	localparam int WRITE_CYCLES = GAP_BASE + 64 + 6;
	localparam int DAC_CYCLES   = 1024;
	localparam int LINES        = 220;
	localparam int LINE_LEN     = 32;
	localparam int SYNC_CYCLES  = 8;
	localparam int VIDEO_CYCLES = LINES * LINE_LEN + 2 * SYNC_CYCLES;
	localparam int TEST_CYCLES  = RESET_CYCLES + IDLE_CYCLES + 4 * CTRL_STEPS
	                            + (NUM_WRITES + 2) * WRITE_CYCLES + DAC_CYCLES + VIDEO_CYCLES + 8;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 5;

	logic       clk_sys = 1'b0;
	logic       rst_n;
	logic [7:0] kbjoy, joy0, joy1;
	logic       upright, snd_req, snd_port, video, hs_in, vs_in;
	logic [5:0] snd_data;
	logic       snd_ack, move_left, move_right, fire, start1, start2, coin;
	logic [7:0] audio_sample;
	logic       audio_bit, r, g, b, hs, vs;

	logic [31:0] lfsr_state = 32'hae9e;
	int          err_count [4] = '{0, 0, 0, 0};

	// Expected outputs and model state
	logic [4:0]            exp_ctrl = '0;
	logic                  exp_coin = 1'b0, exp_ack = 1'b0, exp_bit = 1'b0;
	logic [7:0]            exp_sample = '0, dac_rem = '0;
	logic [2:0]            exp_rgb = '0;
	logic                  exp_hs = 1'b0, exp_vs = 1'b0, hs_prev = 1'b0, coin_key_prev = 1'b0;
	logic [11:0]           snd_state = '0;
	logic [16:0]           voice_st [NUM_VOICES];
	logic [NUM_VOICES-1:0] exp_tones = '0;
	int                    line_cnt = 0, coin_left = 0;

	`include "tb_models.svh"

	arcade_board uut (
		.clk_sys(clk_sys), .rst_n(rst_n), .kbjoy(kbjoy), .joy0(joy0), .joy1(joy1),
		.upright(upright), .snd_req(snd_req), .snd_port(snd_port), .snd_data(snd_data),
		.snd_ack(snd_ack), .video(video), .hs_in(hs_in), .vs_in(vs_in),
		.move_left(move_left), .move_right(move_right), .fire(fire), .start1(start1),
		.start2(start2), .coin(coin), .audio_sample(audio_sample), .audio_bit(audio_bit),
		.r(r), .g(g), .b(b), .hs(hs), .vs(vs)
	);

	always #4 clk_sys = ~clk_sys;

	// ==================================================
	// Compare on the falling edge, then step the model
	// ==================================================
	always @(negedge clk_sys) begin : compare
		logic [8:0] dac_sum;
		check_value(0, "controls", {move_left, move_right, fire, start1, start2}, exp_ctrl);
		check_value(0, "coin", coin, exp_coin);
		check_value(1, "snd_ack", snd_ack, exp_ack);
		check_value(2, "audio_sample", audio_sample, exp_sample);
		check_value(2, "audio_bit", audio_bit, exp_bit);
		check_value(3, "rgb", {r, g, b}, exp_rgb);
		check_value(3, "syncs", {hs, vs}, {exp_hs, exp_vs});
		if (!rst_n) begin
			{exp_ctrl, exp_coin, exp_ack, exp_bit, exp_sample, dac_rem} = '0;
			{exp_rgb, exp_hs, exp_vs, hs_prev, coin_key_prev, snd_state, exp_tones} = '0;
			line_cnt  = 0;
			coin_left = 0;
			for (int i = 0; i < NUM_VOICES; i++)
				voice_st[i] = '0;
		end else begin
			exp_ctrl = ctrl_ref(kbjoy, joy0, joy1, upright);
			if (coin_left > 0)
				coin_left--;
			else if (kbjoy[3] && !coin_key_prev)
				coin_left = COIN_PULSE;
			coin_key_prev = kbjoy[3];
			exp_coin      = (coin_left > 0);

			// Audio pipeline, back to front
			dac_sum    = dac_step(dac_rem, exp_sample);
			exp_bit    = dac_sum[8];
			dac_rem    = dac_sum[7:0];
			exp_sample = mix_level(exp_tones);
			for (int i = 0; i < NUM_VOICES; i++) begin
				voice_st[i]  = voice_step(snd_state[i], voice_st[i], HP_TABLE[i]);
				exp_tones[i] = voice_st[i][16];
			end
			if (snd_req && !exp_ack) begin
				exp_ack = 1'b1;
				if (snd_port)
					snd_state[11:6] = snd_data;
				else
					snd_state[5:0] = snd_data;
			end else if (!snd_req && exp_ack) begin
				exp_ack = 1'b0;
			end

			exp_rgb = overlay_rgb(line_cnt, video);
			exp_hs  = hs_in;
			exp_vs  = vs_in;
			if (vs_in)
				line_cnt = 0;
			else if (hs_in && !hs_prev)
				line_cnt = (line_cnt + 1) % 512;
			hs_prev = hs_in;
		end
	end

	task automatic wait_for_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (snd_ack !== level && n < 16);
		if (snd_ack !== level) begin
			err_count[1]++;
			$display("Handshake stalled: snd_ack did not reach %0b within 16 cycles", level);
		end
	endtask

	task automatic sound_write(input logic port, input logic [5:0] data);
		@(posedge clk_sys);
		snd_port <= port;
		snd_data <= data;
		snd_req  <= 1'b1;
		wait_for_ack(1'b1);
		snd_req <= 1'b0;
		wait_for_ack(1'b0);
	endtask

	task automatic run_controls();
		int hold;
		for (int s = 0; s < CTRL_STEPS; s++) begin
			hold = 1 + int'(take_bits(2));
			@(posedge clk_sys);
			kbjoy   <= 8'(take_bits(8));
			joy0    <= 8'(take_bits(8));
			joy1    <= 8'(take_bits(8));
			upright <= 1'(take_bits(1));
			repeat (hold - 1) @(posedge clk_sys);
		end
		@(posedge clk_sys);
		{kbjoy, joy0, joy1, upright} <= '0;
	endtask

	task automatic vsync_pulse();
		repeat (SYNC_CYCLES) begin
			@(posedge clk_sys);
			vs_in <= 1'b1;
			hs_in <= 1'b0;
			video <= 1'b0;
		end
	endtask

	// Line is hs for 4 cycles, 4 blank cycles, then random pixels
	task automatic run_raster();
		vsync_pulse();
		for (int ln = 0; ln < LINES; ln++) begin
			for (int c = 0; c < LINE_LEN; c++) begin
				@(posedge clk_sys);
				vs_in <= 1'b0;
				hs_in <= (c < 4);
				video <= (c >= 8) ? 1'(take_bits(1)) : 1'b0;
			end
		end
		vsync_pulse();
		@(posedge clk_sys);
		vs_in <= 1'b0;
	endtask

	initial begin : stimulus
		logic       port_sel;
		logic [5:0] data;
		int         total;
		rst_n = 1'b0;
		{kbjoy, joy0, joy1, upright} = '0;
		{snd_req, snd_port, snd_data, video, hs_in, vs_in} = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk_sys);
		run_controls();
		for (int w = 0; w < NUM_WRITES; w++) begin
			port_sel = 1'(take_bits(1));
			data     = 6'(take_bits(6));
			sound_write(port_sel, data);
			repeat (GAP_BASE + int'(take_bits(6))) @(posedge clk_sys);
		end
		// Steady set of voices 0 and 2 for the DAC check
		sound_write(1'b1, 6'd0);
		sound_write(1'b0, 6'b000101);
		repeat (DAC_CYCLES) @(posedge clk_sys);
		run_raster();
		repeat (4) @(posedge clk_sys);
		total = err_count[0] + err_count[1] + err_count[2] + err_count[3];
		$display("Errors: controls %0d, sound %0d, audio %0d, video %0d",
			err_count[0], err_count[1], err_count[2], err_count[3]);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
source/arcade_pkg.sv
source/control_merge.sv
source/sound_latch.sv
source/tone_voice.sv
source/voice_mixer.sv
source/sigma_delta_dac.sv
source/overlay_colorizer.sv
source/arcade_board.sv
+incdir+bench
bench/tb_arcade_board.sv
